// File: bench/tb_app_sideband.sv
`timescale 1ns/1ps
`default_nettype none

module tb_app_sideband;

   import pcie_cfg_pkg::*;
   import app_irq_pkg::*;

   localparam int NUM_VEC = 8;

   typedef struct packed {
      bus_num_t    bus;
      dev_num_t    dev;
      size_code_t  mps;
      size_code_t  mrr;
      link_width_t lw;
      logic        msi_en;
      mme_t        mme;
      logic        intx_dis;
   } dec_t;

   logic        clk;
   logic        rstn;
   busdev_t     cfg_busdev;
   csr32_t      cfg_devcsr;
   csr32_t      cfg_linkcsr;
   csr32_t      cfg_prmcsr;
   tcvcmap_t    cfg_tcvcmap;
   msicsr_t     cfg_msicsr;
   logic        app_int_sts_ack;
   logic        irq_req;
   msi_num_t    irq_vec;
   cpl_err_t    cpl_err;
   logic        cpl_pending;
   bus_num_t    bus_num;
   dev_num_t    dev_num;
   size_code_t  max_payload;
   size_code_t  max_read_req;
   link_width_t link_width;
   logic        msi_enable;
   mme_t        msi_mme;
   logic        int_disable;
   logic        cfg_changed;
   tcvcmap_t    cfg_tcvcmap_app;
   logic        irq_done;
   logic        irq_busy;
   logic        app_int_sts_core;
   msi_num_t    pex_msi_num_core;
   cpl_err_t    cpl_err_core;
   logic        cpl_pending_core;

   integer               seed = 32'h1378e5d0;
   dec_t                 cur_dec = '0;
   logic [NUM_VEC-1:0]   model_pending = '0;
   logic                 exp_msi_en = 1'b0;
   mme_t                 exp_mme = '0;
   logic                 core_hold = 1'b0;
   logic [1:0]           core_state;
   int                   ack_delay;
   int                   served_cnt = 0;
   int                   ack_cnt = 0;
   int                   done_cnt = 0;
   int                   ack_age = 100;
   int                   low_idx;
   logic                 prev_sts = 1'b0;

   tb_clkgen u_clkgen (
      .clk  (clk),
      .rstn (rstn)
   );

   app_sideband_top #(
      .NUM_VEC (NUM_VEC)
   ) u_dut (
      .clk (clk), .rstn (rstn),
      .cfg_busdev (cfg_busdev), .cfg_devcsr (cfg_devcsr), .cfg_linkcsr (cfg_linkcsr),
      .cfg_prmcsr (cfg_prmcsr), .cfg_tcvcmap (cfg_tcvcmap), .cfg_msicsr (cfg_msicsr),
      .app_int_sts_ack (app_int_sts_ack), .irq_req (irq_req), .irq_vec (irq_vec),
      .cpl_err (cpl_err), .cpl_pending (cpl_pending),
      .bus_num (bus_num), .dev_num (dev_num), .max_payload (max_payload),
      .max_read_req (max_read_req), .link_width (link_width), .msi_enable (msi_enable),
      .msi_mme (msi_mme), .int_disable (int_disable), .cfg_changed (cfg_changed),
      .cfg_tcvcmap_app (cfg_tcvcmap_app), .irq_done (irq_done), .irq_busy (irq_busy),
      .app_int_sts_core (app_int_sts_core), .pex_msi_num_core (pex_msi_num_core),
      .cpl_err_core (cpl_err_core), .cpl_pending_core (cpl_pending_core)
   );

   function automatic logic [31:0] rnd();
      rnd = $random(seed);
   endfunction

   // field positions as the core lays out its configuration registers.
   function automatic dec_t decode_ref(busdev_t busdev, csr32_t devcsr, csr32_t linkcsr,
                                       csr32_t prmcsr, msicsr_t msicsr);
      dec_t d;
      d.bus      = busdev[12:5];
      d.dev      = busdev[4:0];
      d.mps      = devcsr[7:5];
      d.mrr      = devcsr[14:12];
      d.lw       = linkcsr[25:20];
      d.msi_en   = msicsr[0];
      d.mme      = msicsr[6:4];
      d.intx_dis = prmcsr[10];
      return d;
   endfunction

   // 2**mme vectors are allocated and legacy INTx always reports vector 0.
   function automatic msi_num_t irq_ref(int vec, logic msi_en, mme_t mme);
      if (!msi_en)
         return '0;
      else
         return msi_num_t'(vec % (1 << mme));
   endfunction

   task automatic stop_run(string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at %0t", $time);
   endtask

   task automatic report_error(string name, logic [31:0] exp, logic [31:0] act);
      stop_run($sformatf("Error: time %0t, %s expected 0x%0h, got 0x%0h",
                         $time, name, exp, act));
   endtask

   task automatic check_size(string name, size_code_t exp, size_code_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_width(string name, link_width_t exp, link_width_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_bus(string name, bus_num_t exp, bus_num_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_dev(string name, dev_num_t exp, dev_num_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_mme(string name, mme_t exp, mme_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_tcvc(string name, tcvcmap_t exp, tcvcmap_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_msi(string name, msi_num_t exp, msi_num_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_cpl(string name, cpl_err_t exp, cpl_err_t act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) report_error(name, exp, act);
   endtask

   task automatic check_decoded(dec_t exp);
      check_bus("bus_num", exp.bus, bus_num);
      check_dev("dev_num", exp.dev, dev_num);
      check_size("max_payload", exp.mps, max_payload);
      check_size("max_read_req", exp.mrr, max_read_req);
      check_width("link_width", exp.lw, link_width);
      check_bit("msi_enable", exp.msi_en, msi_enable);
      check_mme("msi_mme", exp.mme, msi_mme);
      check_bit("int_disable", exp.intx_dis, int_disable);
   endtask

   // the core model acks each request after a random 1 to 4 cycles.
   always @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         app_int_sts_ack <= 1'b0;
         core_state      <= 2'd0;
         ack_delay       <= 0;
      end else begin
         app_int_sts_ack <= 1'b0;
         case (core_state)
            2'd0: begin
               if (app_int_sts_core && !core_hold) begin
                  ack_delay  <= rnd() % 4;
                  core_state <= 2'd1;
               end
            end
            2'd1: begin
               if (ack_delay == 0) begin
                  app_int_sts_ack <= 1'b1;
                  core_state      <= 2'd2;
               end else begin
                  ack_delay <= ack_delay - 1;
               end
            end
            default: begin
               if (!app_int_sts_core)
                  core_state <= 2'd0;
            end
         endcase
      end
   end

   // the interrupt path is checked on the falling edge.
   always @(negedge clk) begin
      if (rstn) begin
         if (app_int_sts_core && !prev_sts) begin
            if (model_pending == '0)
               stop_run("app_int_sts_core rose while no vector was pending");
            low_idx = 0;
            for (int i = NUM_VEC - 1; i >= 0; i--)
               if (model_pending[i]) low_idx = i;
            check_msi("pex_msi_num_core", irq_ref(low_idx, exp_msi_en, exp_mme),
                      pex_msi_num_core);
            check_bit("irq_busy", 1'b1, irq_busy);
            model_pending[low_idx] = 1'b0;
            served_cnt++;
         end
         if (app_int_sts_ack) begin
            ack_age = 0;
            ack_cnt++;
         end else if (ack_age < 100) begin
            ack_age++;
         end
         // done follows the ack by 2 cycles and the request drops after 3.
         check_bit("irq_done", ack_age == 2, irq_done);
         if (ack_age < 3)
            check_bit("app_int_sts_core", 1'b1, app_int_sts_core);
         else if (ack_age == 3)
            check_bit("app_int_sts_core", 1'b0, app_int_sts_core);
         if (irq_done)
            done_cnt++;
         prev_sts = app_int_sts_core;
      end
   end

   task automatic apply_cfg(busdev_t busdev, csr32_t devcsr, csr32_t linkcsr,
                            csr32_t prmcsr, tcvcmap_t tcvc, msicsr_t msicsr);
      dec_t nxt;
      logic pulse;
      nxt   = decode_ref(busdev, devcsr, linkcsr, prmcsr, msicsr);
      pulse = (nxt != cur_dec);
      @(posedge clk);
      cfg_busdev  <= busdev;
      cfg_devcsr  <= devcsr;
      cfg_linkcsr <= linkcsr;
      cfg_prmcsr  <= prmcsr;
      cfg_tcvcmap <= tcvc;
      cfg_msicsr  <= msicsr;
      repeat (2) begin
         @(negedge clk);
         check_decoded(cur_dec);
         check_bit("cfg_changed", 1'b0, cfg_changed);
      end
      @(negedge clk);
      check_decoded(nxt);
      check_tcvc("cfg_tcvcmap_app", tcvc, cfg_tcvcmap_app);
      check_bit("cfg_changed", pulse, cfg_changed);
      @(negedge clk);
      check_bit("cfg_changed", 1'b0, cfg_changed);
      cur_dec = nxt;
   endtask

   task automatic strobe_one(msi_num_t v);
      @(posedge clk);
      irq_req <= 1'b1;
      irq_vec <= v;
      if (v < NUM_VEC)
         model_pending[v] = 1'b1;
      @(posedge clk);
      irq_req <= 1'b0;
   endtask

   task automatic wait_served(int target, int limit);
      int n;
      n = 0;
      while (served_cnt < target) begin
         @(posedge clk);
         n++;
         if (n > limit)
            stop_run($sformatf("timeout: request %0d never reached app_int_sts_core", target));
      end
   endtask

   task automatic wait_idle(int limit);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > limit)
            stop_run("timeout: interrupt handshake did not return to idle");
      end while (app_int_sts_core || irq_busy || ack_age <= 3);
      if (done_cnt != ack_cnt || ack_cnt != served_cnt)
         stop_run("irq_done pulses, acknowledges and served requests do not match");
   endtask

   task automatic hold_low(int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_bit("app_int_sts_core", 1'b0, app_int_sts_core);
         check_bit("irq_busy", 1'b0, irq_busy);
      end
   endtask

   task automatic run_cpl_test();
      cpl_err_t e;
      cpl_err_t last_e;
      logic     p;
      logic     last_p;
      last_e = cpl_err;
      last_p = cpl_pending;
      for (int i = 0; i < 20; i++) begin
         e = cpl_err_t'(rnd());
         p = rnd() % 2;
         @(posedge clk);
         cpl_err     <= e;
         cpl_pending <= p;
         @(negedge clk);
         check_cpl("cpl_err_core", last_e, cpl_err_core);
         check_bit("cpl_pending_core", last_p, cpl_pending_core);
         last_e = e;
         last_p = p;
      end
   endtask

   task automatic run_msi_test();
      msi_num_t first;
      msi_num_t vecs[3];
      int       target;
      for (int round = 0; round < 3; round++) begin
         apply_cfg(cfg_busdev, cfg_devcsr, cfg_linkcsr, cfg_prmcsr, cfg_tcvcmap,
                   msicsr_t'(rnd()) | 16'h0001);
         exp_msi_en = 1'b1;
         exp_mme    = cur_dec.mme;
         core_hold  = 1'b1;
         first      = msi_num_t'(rnd() % NUM_VEC);
         for (int k = 0; k < 3; k++) begin
            vecs[k] = msi_num_t'(rnd() % NUM_VEC);
            if (vecs[k] == first)
               vecs[k] = first ^ 5'd1;
         end
         strobe_one(first);
         wait_served(served_cnt + 1, 20);
         // the burst repeats each vector, so every vector must be served once.
         for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            irq_req <= 1'b1;
            irq_vec <= vecs[k % 3];
            model_pending[vecs[k % 3]] = 1'b1;
         end
         @(posedge clk);
         irq_req <= 1'b0;
         target = served_cnt + $countones(model_pending);
         @(negedge clk);
         core_hold = 1'b0;
         wait_served(target, 200);
         wait_idle(40);
         hold_low(10);
      end
   endtask

   task automatic run_legacy_test();
      int target;
      exp_msi_en = 1'b0;
      apply_cfg(cfg_busdev, cfg_devcsr, cfg_linkcsr, cfg_prmcsr & ~32'h400, cfg_tcvcmap,
                16'h0000);
      strobe_one(msi_num_t'(rnd() % NUM_VEC));
      wait_served(served_cnt + 1, 40);
      wait_idle(40);
      apply_cfg(cfg_busdev, cfg_devcsr, cfg_linkcsr, cfg_prmcsr | 32'h400, cfg_tcvcmap,
                16'h0000);
      target = served_cnt + 1;
      strobe_one(msi_num_t'(rnd() % NUM_VEC));
      hold_low(30);
      apply_cfg(cfg_busdev, cfg_devcsr, cfg_linkcsr, cfg_prmcsr & ~32'h400, cfg_tcvcmap,
                16'h0000);
      wait_served(target, 40);
      wait_idle(40);
      strobe_one(msi_num_t'(NUM_VEC + rnd() % (32 - NUM_VEC)));
      hold_low(20);
   endtask

   initial begin
      cfg_busdev      = '0;
      cfg_devcsr      = '0;
      cfg_linkcsr     = '0;
      cfg_prmcsr      = '0;
      cfg_tcvcmap     = '0;
      cfg_msicsr      = '0;
      app_int_sts_ack = 1'b0;
      irq_req         = 1'b0;
      irq_vec         = '0;
      cpl_err         = '0;
      cpl_pending     = 1'b0;
      for (int n = 0; rstn !== 1'b1; n++) begin
         @(negedge clk);
         if (n > 20)
            stop_run("timeout: reset was never released");
      end
      check_decoded('0);
      check_bit("app_int_sts_core", 1'b0, app_int_sts_core);
      check_bit("cfg_changed", 1'b0, cfg_changed);
      check_bit("irq_done", 1'b0, irq_done);
      check_bit("irq_busy", 1'b0, irq_busy);
      for (int i = 0; i < 24; i++) begin
         if (i % 4 == 3)
            apply_cfg(cfg_busdev, cfg_devcsr, cfg_linkcsr, cfg_prmcsr, cfg_tcvcmap,
                      cfg_msicsr);
         else
            apply_cfg(busdev_t'(rnd()), rnd(), rnd(), rnd(), tcvcmap_t'(rnd()),
                      msicsr_t'(rnd()));
      end
      run_cpl_test();
      run_msi_test();
      run_legacy_test();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter real PERIOD     = 10.0,
   parameter int  RST_CYCLES = 3
) (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

   // reset is released on a rising edge like any other input.
   initial begin
      rstn = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rstn <= 1'b1;
   end

endmodule

`default_nettype wire

// File: tb.f
verilog/pcie_cfg_pkg.sv
verilog/app_irq_pkg.sv
verilog/icm_sideband.sv
verilog/cfg_decode.sv
verilog/irq_ctrl.sv
verilog/app_sideband_top.sv
bench/tb_clkgen.sv
bench/tb_app_sideband.sv

// File: verilog/app_irq_pkg.sv
`default_nettype none

package app_irq_pkg;

   // vector number carried on pex_msi_num.
   typedef logic [4:0] msi_num_t;

   // completion error flags reported by the application.
   typedef logic [2:0] cpl_err_t;

endpackage

`default_nettype wire

// File: verilog/app_sideband_top.sv
`timescale 1ns/1ps
`default_nettype none

module app_sideband_top #(
   parameter int NUM_VEC = 8
) (
   input  wire                             clk,
   input  wire                             rstn,
   input  wire pcie_cfg_pkg::busdev_t      cfg_busdev,
   input  wire pcie_cfg_pkg::csr32_t       cfg_devcsr,
   input  wire pcie_cfg_pkg::csr32_t       cfg_linkcsr,
   input  wire pcie_cfg_pkg::csr32_t       cfg_prmcsr,
   input  wire pcie_cfg_pkg::tcvcmap_t     cfg_tcvcmap,
   input  wire pcie_cfg_pkg::msicsr_t      cfg_msicsr,
   input  wire                             app_int_sts_ack,
   input  wire                             irq_req,
   input  wire app_irq_pkg::msi_num_t      irq_vec,
   input  wire app_irq_pkg::cpl_err_t      cpl_err,
   input  wire                             cpl_pending,
   output wire pcie_cfg_pkg::bus_num_t     bus_num,
   output wire pcie_cfg_pkg::dev_num_t     dev_num,
   output wire pcie_cfg_pkg::size_code_t   max_payload,
   output wire pcie_cfg_pkg::size_code_t   max_read_req,
   output wire pcie_cfg_pkg::link_width_t  link_width,
   output wire                             msi_enable,
   output wire pcie_cfg_pkg::mme_t         msi_mme,
   output wire                             int_disable,
   output wire                             cfg_changed,
   output wire pcie_cfg_pkg::tcvcmap_t     cfg_tcvcmap_app,
   output wire                             irq_done,
   output wire                             irq_busy,
   output wire                             app_int_sts_core,
   output wire app_irq_pkg::msi_num_t      pex_msi_num_core,
   output wire app_irq_pkg::cpl_err_t      cpl_err_core,
   output wire                             cpl_pending_core
);

   import pcie_cfg_pkg::*;
   import app_irq_pkg::*;

   busdev_t  busdev_del;
   csr32_t   devcsr_del;
   csr32_t   linkcsr_del;
   csr32_t   prmcsr_del;
   msicsr_t  msicsr_del;
   logic     ack_del;
   logic     irq_sts;
   msi_num_t irq_msi_num;

   icm_sideband u_sideband (
      .clk                 (clk),
      .rstn                (rstn),
      .cfg_busdev          (cfg_busdev),
      .cfg_devcsr          (cfg_devcsr),
      .cfg_linkcsr         (cfg_linkcsr),
      .cfg_prmcsr          (cfg_prmcsr),
      .cfg_tcvcmap         (cfg_tcvcmap),
      .cfg_msicsr          (cfg_msicsr),
      .app_int_sts_ack     (app_int_sts_ack),
      .app_int_sts         (irq_sts),
      .pex_msi_num         (irq_msi_num),
      .cpl_err             (cpl_err),
      .cpl_pending         (cpl_pending),
      .cfg_busdev_del      (busdev_del),
      .cfg_devcsr_del      (devcsr_del),
      .cfg_linkcsr_del     (linkcsr_del),
      .cfg_prmcsr_del      (prmcsr_del),
      .cfg_tcvcmap_del     (cfg_tcvcmap_app),
      .cfg_msicsr_del      (msicsr_del),
      .app_int_sts_ack_del (ack_del),
      .app_int_sts_del     (app_int_sts_core),
      .pex_msi_num_del     (pex_msi_num_core),
      .cpl_err_del         (cpl_err_core),
      .cpl_pending_del     (cpl_pending_core)
   );

   cfg_decode u_decode (
      .clk          (clk),
      .rstn         (rstn),
      .cfg_busdev   (busdev_del),
      .cfg_devcsr   (devcsr_del),
      .cfg_linkcsr  (linkcsr_del),
      .cfg_prmcsr   (prmcsr_del),
      .cfg_msicsr   (msicsr_del),
      .bus_num      (bus_num),
      .dev_num      (dev_num),
      .max_payload  (max_payload),
      .max_read_req (max_read_req),
      .link_width   (link_width),
      .msi_enable   (msi_enable),
      .msi_mme      (msi_mme),
      .int_disable  (int_disable),
      .cfg_changed  (cfg_changed)
   );

   irq_ctrl #(
      .NUM_VEC (NUM_VEC)
   ) u_irq (
      .clk         (clk),
      .rstn        (rstn),
      .irq_req     (irq_req),
      .irq_vec     (irq_vec),
      .msi_enable  (msi_enable),
      .int_disable (int_disable),
      .msi_mme     (msi_mme),
      .int_ack     (ack_del),
      .app_int_sts (irq_sts),
      .pex_msi_num (irq_msi_num),
      .irq_done    (irq_done),
      .irq_busy    (irq_busy)
   );

endmodule

`default_nettype wire

// File: verilog/cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_decode (
   input  wire                            clk,
   input  wire                            rstn,
   input  wire pcie_cfg_pkg::busdev_t     cfg_busdev,
   input  wire pcie_cfg_pkg::csr32_t      cfg_devcsr,
   input  wire pcie_cfg_pkg::csr32_t      cfg_linkcsr,
   input  wire pcie_cfg_pkg::csr32_t      cfg_prmcsr,
   input  wire pcie_cfg_pkg::msicsr_t     cfg_msicsr,
   output pcie_cfg_pkg::bus_num_t         bus_num,
   output pcie_cfg_pkg::dev_num_t         dev_num,
   output pcie_cfg_pkg::size_code_t       max_payload,
   output pcie_cfg_pkg::size_code_t       max_read_req,
   output pcie_cfg_pkg::link_width_t      link_width,
   output logic                           msi_enable,
   output pcie_cfg_pkg::mme_t             msi_mme,
   output logic                           int_disable,
   output logic                           cfg_changed
);

   import pcie_cfg_pkg::*;

   bus_num_t    bus_nxt;
   dev_num_t    dev_nxt;
   size_code_t  mps_nxt;
   size_code_t  mrr_nxt;
   link_width_t lw_nxt;
   logic        msi_en_nxt;
   mme_t        mme_nxt;
   logic        intx_dis_nxt;
   logic        diff;

   always_comb begin
      dev_nxt      = cfg_busdev[0 +: $bits(dev_num_t)];
      bus_nxt      = cfg_busdev[$bits(dev_num_t) +: $bits(bus_num_t)];
      mps_nxt      = cfg_devcsr[MPS_LSB +: $bits(size_code_t)];
      mrr_nxt      = cfg_devcsr[MRR_LSB +: $bits(size_code_t)];
      lw_nxt       = cfg_linkcsr[LWIDTH_LSB +: $bits(link_width_t)];
      msi_en_nxt   = cfg_msicsr[MSI_EN_BIT];
      mme_nxt      = cfg_msicsr[MME_LSB +: $bits(mme_t)];
      intx_dis_nxt = cfg_prmcsr[INTX_DIS_BIT];
   end

   // compare against what is currently held, so the strobe lines up
   // with the first cycle the new values are visible.
   assign diff = (bus_nxt != bus_num) || (dev_nxt != dev_num) ||
                 (mps_nxt != max_payload) || (mrr_nxt != max_read_req) ||
                 (lw_nxt != link_width) || (msi_en_nxt != msi_enable) ||
                 (mme_nxt != msi_mme) || (intx_dis_nxt != int_disable);

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         bus_num      <= '0;
         dev_num      <= '0;
         max_payload  <= '0;
         max_read_req <= '0;
         link_width   <= '0;
         msi_enable   <= 1'b0;
         msi_mme      <= '0;
         int_disable  <= 1'b0;
         cfg_changed  <= 1'b0;
      end else begin
         bus_num      <= bus_nxt;
         dev_num      <= dev_nxt;
         max_payload  <= mps_nxt;
         max_read_req <= mrr_nxt;
         link_width   <= lw_nxt;
         msi_enable   <= msi_en_nxt;
         msi_mme      <= mme_nxt;
         int_disable  <= intx_dis_nxt;
         cfg_changed  <= diff;
      end
   end

endmodule

`default_nettype wire

// File: verilog/icm_sideband.sv
`timescale 1ns/1ps
`default_nettype none

module icm_sideband (
   input  wire                           clk,
   input  wire                           rstn,
   input  wire pcie_cfg_pkg::busdev_t    cfg_busdev,
   input  wire pcie_cfg_pkg::csr32_t     cfg_devcsr,
   input  wire pcie_cfg_pkg::csr32_t     cfg_linkcsr,
   input  wire pcie_cfg_pkg::csr32_t     cfg_prmcsr,
   input  wire pcie_cfg_pkg::tcvcmap_t   cfg_tcvcmap,
   input  wire pcie_cfg_pkg::msicsr_t    cfg_msicsr,
   input  wire                           app_int_sts_ack,
   input  wire                           app_int_sts,
   input  wire app_irq_pkg::msi_num_t    pex_msi_num,
   input  wire app_irq_pkg::cpl_err_t    cpl_err,
   input  wire                           cpl_pending,
   output pcie_cfg_pkg::busdev_t         cfg_busdev_del,
   output pcie_cfg_pkg::csr32_t          cfg_devcsr_del,
   output pcie_cfg_pkg::csr32_t          cfg_linkcsr_del,
   output pcie_cfg_pkg::csr32_t          cfg_prmcsr_del,
   output pcie_cfg_pkg::tcvcmap_t        cfg_tcvcmap_del,
   output pcie_cfg_pkg::msicsr_t         cfg_msicsr_del,
   output logic                          app_int_sts_ack_del,
   output logic                          app_int_sts_del,
   output app_irq_pkg::msi_num_t         pex_msi_num_del,
   output app_irq_pkg::cpl_err_t         cpl_err_del,
   output logic                          cpl_pending_del
);

   // one flop per signal in each direction so that the core boundary
   // is a clean register-to-register path.
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         cfg_busdev_del      <= '0;
         cfg_devcsr_del      <= '0;
         cfg_linkcsr_del     <= '0;
         cfg_prmcsr_del      <= '0;
         cfg_tcvcmap_del     <= '0;
         cfg_msicsr_del      <= '0;
         app_int_sts_ack_del <= 1'b0;
         app_int_sts_del     <= 1'b0;
         pex_msi_num_del     <= '0;
         cpl_err_del         <= '0;
         cpl_pending_del     <= 1'b0;
      end else begin
         cfg_busdev_del      <= cfg_busdev;
         cfg_devcsr_del      <= cfg_devcsr;
         cfg_linkcsr_del     <= cfg_linkcsr;
         cfg_prmcsr_del      <= cfg_prmcsr;
         cfg_tcvcmap_del     <= cfg_tcvcmap;
         cfg_msicsr_del      <= cfg_msicsr;
         app_int_sts_ack_del <= app_int_sts_ack;
         app_int_sts_del     <= app_int_sts;
         pex_msi_num_del     <= pex_msi_num;
         cpl_err_del         <= cpl_err;
         cpl_pending_del     <= cpl_pending;
      end
   end

endmodule

`default_nettype wire

// File: verilog/irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl #(
   parameter int NUM_VEC = 8
) (
   input  wire                           clk,
   input  wire                           rstn,
   input  wire                           irq_req,
   input  wire app_irq_pkg::msi_num_t    irq_vec,
   input  wire                           msi_enable,
   input  wire                           int_disable,
   input  wire pcie_cfg_pkg::mme_t       msi_mme,
   input  wire                           int_ack,
   output logic                          app_int_sts,
   output app_irq_pkg::msi_num_t         pex_msi_num,
   output logic                          irq_done,
   output logic                          irq_busy
);

   import app_irq_pkg::*;
   import pcie_cfg_pkg::*;

   localparam logic [NUM_VEC-1:0] VEC_ONE = 1;

   logic [NUM_VEC-1:0] pending;
   logic [NUM_VEC-1:0] set_mask;
   logic [NUM_VEC-1:0] clr_mask;
   logic               found;
   logic               can_issue;
   msi_num_t           low_vec;
   msi_num_t           cur_vec;

   // with 2**mme vectors allocated the core only sees the low mme bits.
   function automatic msi_num_t msi_fold(msi_num_t vec, mme_t mme);
      logic [31:0] mask;
      mask = ~(32'hffff_ffff << mme);
      return vec & mask[$bits(msi_num_t)-1:0];
   endfunction

   // out of range vectors are dropped here.
   assign set_mask = (irq_req && (int'(irq_vec) < NUM_VEC)) ? (VEC_ONE << irq_vec) : '0;
   assign clr_mask = (app_int_sts && int_ack) ? (VEC_ONE << cur_vec) : '0;

   assign can_issue = msi_enable || !int_disable;
   assign irq_busy  = app_int_sts;

   // lowest pending vector wins.
   always_comb begin
      found   = 1'b0;
      low_vec = '0;
      for (int i = NUM_VEC - 1; i >= 0; i--) begin
         if (pending[i]) begin
            found   = 1'b1;
            low_vec = msi_num_t'(i);
         end
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         pending     <= '0;
         app_int_sts <= 1'b0;
         cur_vec     <= '0;
         pex_msi_num <= '0;
         irq_done    <= 1'b0;
      end else begin
         // a fresh strobe for the vector being acknowledged survives the clear.
         pending  <= (pending & ~clr_mask) | set_mask;
         irq_done <= 1'b0;
         if (app_int_sts) begin
            if (int_ack) begin
               app_int_sts <= 1'b0;
               irq_done    <= 1'b1;
            end
         end else if (found && can_issue) begin
            // only reached with app_int_sts low, so there is always
            // at least one low cycle between two requests.
            app_int_sts <= 1'b1;
            cur_vec     <= low_vec;
            pex_msi_num <= msi_enable ? msi_fold(low_vec, msi_mme) : '0;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/pcie_cfg_pkg.sv
`default_nettype none

package pcie_cfg_pkg;

   // register images as the hard core presents them.
   typedef logic [12:0] busdev_t;
   typedef logic [31:0] csr32_t;
   typedef logic [23:0] tcvcmap_t;
   typedef logic [15:0] msicsr_t;

   // fields the application actually looks at.
   typedef logic [7:0] bus_num_t;
   typedef logic [4:0] dev_num_t;
   typedef logic [2:0] size_code_t;
   typedef logic [5:0] link_width_t;
   typedef logic [2:0] mme_t;

   // bit positions of the decoded fields inside the register images.
   // the bus number sits above the device number in busdev.
   localparam int MPS_LSB      = 5;
   localparam int MRR_LSB      = 12;
   localparam int LWIDTH_LSB   = 20;
   localparam int MME_LSB      = 4;
   localparam int MSI_EN_BIT   = 0;
   localparam int INTX_DIS_BIT = 10;

endpackage

`default_nettype wire
